// File: common/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define CACHE_ADDR_W      32  // byte address
`define CACHE_DATA_W      32  // cpu word
`define CACHE_OFFSET_W    4   // 16-byte lines
`define CACHE_INDEX_W     6   // 64 lines
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)
`define CACHE_LINE_W      128

// derived from the above
`define CACHE_BYTE_OFF_W  2   // bytes within a word
`define CACHE_WSEL_W      (`CACHE_OFFSET_W - `CACHE_BYTE_OFF_W)
`define CACHE_WORDS       (`CACHE_LINE_W / `CACHE_DATA_W)
`define CACHE_LINES       (1 << `CACHE_INDEX_W)

`endif

// File: common/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]      tag;
    logic [`CACHE_INDEX_W-1:0]    index;
    logic [`CACHE_WSEL_W-1:0]     word_sel;
    logic [`CACHE_BYTE_OFF_W-1:0] byte_off;
  } addr_fields_t;

  // flat word for the memory port, split fields for the stores
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] word;
    addr_fields_t             f;
  } cache_addr_u;

  typedef logic [`CACHE_WORDS-1:0][`CACHE_DATA_W-1:0] line_t; // word 0 at the low end

  typedef struct packed {
    logic                     rden;
    logic                     wren;
    cache_addr_u              addr;
    logic [`CACHE_DATA_W-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic        rden;
    logic        wren;
    cache_addr_u addr;   // line aligned
    line_t       wdata;  // victim line on write-back
  } mem_req_t;

endpackage

// File: common/ctrl_pkg.sv
package ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    COMPARE_TAG,
    WRITE_BACK,
    ALLOCATE,
    CACHE_ACCESS
  } ctrl_state_e;

  typedef struct packed {
    logic cache_rden;   // word read or victim read
    logic cache_wren;   // data store write
    logic cache_insel;  // 1 fill line from memory, 0 cpu word
    logic set_dirty;    // dirty value on entry update
    logic set_valid;    // entry update, qualified by cache_wren
    logic replace_tag;  // load request tag into the entry
    logic tag_sel;      // stored tag onto the memory address
  } cache_ctrl_t;

endpackage

// File: cache/cache_tag_store.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tag_store (
  input  logic                   clk,
  input  logic                   rst,
  input  cache_pkg::cpu_req_t    cpu,
  input  logic                   stall,
  input  ctrl_pkg::cache_ctrl_t  ctrl,
  output cache_pkg::cpu_req_t    req,
  output logic                   hit,
  output logic                   dirty,
  output cache_pkg::cache_addr_u mem_addr
);

  logic [`CACHE_TAG_W-1:0]   tag_q [`CACHE_LINES];
  logic [`CACHE_LINES-1:0]   valid_q;
  logic [`CACHE_LINES-1:0]   dirty_q;
  logic [`CACHE_INDEX_W-1:0] idx;
  logic [`CACHE_TAG_W-1:0]   req_tag;

  assign idx     = req.addr.f.index;
  assign req_tag = req.addr.f.tag;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req <= '0;
    end else if (!stall) begin
      req <= cpu; // held through a miss
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
      for (int i = 0; i < `CACHE_LINES; i++) begin
        tag_q[i] <= '0;
      end
    end else begin
      if (ctrl.replace_tag) begin
        tag_q[idx] <= req_tag;
      end
      if (ctrl.cache_wren && ctrl.set_valid) begin // write hit or fill
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= ctrl.set_dirty;
      end
    end
  end

  assign hit   = valid_q[idx] && (tag_q[idx] == req_tag);
  assign dirty = dirty_q[idx];

  always_comb begin
    mem_addr            = req.addr;
    mem_addr.f.word_sel = '0; // line aligned
    mem_addr.f.byte_off = '0;
    if (ctrl.tag_sel) begin
      mem_addr.f.tag = tag_q[idx]; // victim line address
    end
  end

  // an invalid line turns valid only with its tag loaded
  assert property (@(posedge clk) disable iff (rst)
    ctrl.cache_wren && ctrl.set_valid && !valid_q[idx] |-> ctrl.replace_tag);

  // after a fill the held request must hit in CACHE_ACCESS
  assert property (@(posedge clk) disable iff (rst)
    ctrl.cache_wren && ctrl.cache_insel |=> hit);

endmodule

// File: cache/cache_fsm.sv
`timescale 1ns/1ps

module cache_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cpu_rden,
  input  logic                  cpu_wren,
  input  logic                  req_rden,
  input  logic                  req_wren,
  input  logic                  hit,
  input  logic                  dirty,
  input  logic                  mem_ready,
  output ctrl_pkg::cache_ctrl_t ctrl,
  output logic                  mem_rden,
  output logic                  mem_wren,
  output logic                  stall,
  output logic                  rvalid
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;
  logic                  cpu_req; // live request, not yet registered

  assign cpu_req = cpu_rden || cpu_wren;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d  = state_q;
    ctrl     = '0;
    mem_rden = 1'b0;
    mem_wren = 1'b0;
    stall    = 1'b0;
    case (state_q)
      ctrl_pkg::IDLE: begin
        if (cpu_req) begin
          state_d = ctrl_pkg::COMPARE_TAG;
        end
      end
      ctrl_pkg::COMPARE_TAG: begin
        if (hit) begin
          ctrl.cache_rden  = req_rden;
          ctrl.cache_wren  = req_wren;
          ctrl.set_dirty   = 1'b1;
          ctrl.set_valid   = 1'b1;
          ctrl.replace_tag = req_wren;
          if (cpu_req) begin
            state_d = ctrl_pkg::COMPARE_TAG; // back-to-back access
          end else begin
            state_d = ctrl_pkg::IDLE;
          end
        end else if (dirty) begin
          ctrl.cache_rden = 1'b1; // victim line onto mem wdata
          ctrl.set_dirty  = req_wren;
          ctrl.set_valid  = 1'b1;
          ctrl.tag_sel    = 1'b1; // victim tag on the address
          mem_wren        = 1'b1;
          stall           = 1'b1;
          state_d         = ctrl_pkg::WRITE_BACK;
        end else begin
          ctrl.set_dirty = req_wren;
          ctrl.set_valid = 1'b1;
          mem_rden       = 1'b1; // clean miss fetches at once
          stall          = 1'b1;
          state_d        = ctrl_pkg::ALLOCATE;
        end
      end
      ctrl_pkg::WRITE_BACK: begin
        stall = 1'b1;
        if (mem_ready) begin
          ctrl.cache_insel = 1'b1;
          mem_rden         = 1'b1; // fetch follows write-back ack
          state_d          = ctrl_pkg::ALLOCATE;
        end else begin
          ctrl.cache_rden = 1'b1;
          ctrl.set_dirty  = req_wren;
          ctrl.set_valid  = 1'b1;
          ctrl.tag_sel    = 1'b1;
          mem_wren        = 1'b1;
        end
      end
      ctrl_pkg::ALLOCATE: begin
        stall = 1'b1;
        if (mem_ready) begin
          ctrl.cache_wren  = 1'b1; // mem_rdata valid this cycle
          ctrl.cache_insel = 1'b1;
          ctrl.set_dirty   = req_wren; // write miss leaves the line dirty
          ctrl.set_valid   = 1'b1;
          ctrl.replace_tag = 1'b1;
          state_d          = ctrl_pkg::CACHE_ACCESS;
        end else begin
          mem_rden = 1'b1;
        end
      end
      ctrl_pkg::CACHE_ACCESS: begin
        ctrl.cache_rden = req_rden;
        ctrl.cache_wren = req_wren; // same word again, already merged
        if (cpu_req) begin
          state_d = ctrl_pkg::COMPARE_TAG;
        end else begin
          state_d = ctrl_pkg::IDLE;
        end
      end
      default: begin
        stall   = 1'b1;
        state_d = ctrl_pkg::IDLE;
      end
    endcase
  end

  // read data goes out only once the cpu is released
  assign rvalid = req_rden && ctrl.cache_rden && !stall;

  assert property (@(posedge clk) disable iff (rst) !(mem_rden && mem_wren));

  // the cpu is released before the FSM goes idle
  assert property (@(posedge clk) disable iff (rst)
    state_q == ctrl_pkg::IDLE |-> !$past(stall));

endmodule

// File: cache/cache_data_store.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_data_store (
  input  logic                     clk,
  input  logic                     rst,
  input  ctrl_pkg::cache_ctrl_t    ctrl,
  input  cache_pkg::cpu_req_t      req,
  input  cache_pkg::line_t         mem_rdata,
  output logic [`CACHE_DATA_W-1:0] rdata,
  output cache_pkg::line_t         victim_line
);

  cache_pkg::line_t          lines_q [`CACHE_LINES];
  cache_pkg::line_t          fill_line;
  logic [`CACHE_INDEX_W-1:0] idx;
  logic [`CACHE_WSEL_W-1:0]  wsel;

  assign idx  = req.addr.f.index;
  assign wsel = req.addr.f.word_sel;

  always_comb begin
    fill_line = mem_rdata;
    if (req.wren) begin
      fill_line[wsel] = req.wdata; // write-allocate merge
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.cache_wren) begin
      if (ctrl.cache_insel) begin
        lines_q[idx] <= fill_line;
      end else begin
        lines_q[idx][wsel] <= req.wdata; // store hit
      end
    end
  end

  assign victim_line = lines_q[idx]; // read before the fill overwrites it
  assign rdata       = lines_q[idx][wsel];

  // the fetched word reaches the cpu in the CACHE_ACCESS cycle
  assert property (@(posedge clk) disable iff (rst)
    ctrl.cache_wren && ctrl.cache_insel && req.rden
    |=> rdata == $past(mem_rdata[wsel]));

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module dcache_top (
  input  logic                     clk,
  input  logic                     rst,
  input  cache_pkg::cpu_req_t      cpu,
  output logic                     stall,
  output logic [`CACHE_DATA_W-1:0] rdata,
  output logic                     rvalid,
  output cache_pkg::mem_req_t      mem,
  input  logic                     mem_ready,
  input  cache_pkg::line_t         mem_rdata
);

  cache_pkg::cpu_req_t    req;          // registered request
  ctrl_pkg::cache_ctrl_t  ctrl;
  cache_pkg::cache_addr_u mem_addr;
  cache_pkg::line_t       victim_line;
  logic                   hit;
  logic                   dirty;
  logic                   mem_rden;
  logic                   mem_wren;

  cache_tag_store tag_store_i (
    .clk      (clk),
    .rst      (rst),
    .cpu      (cpu),
    .stall    (stall),
    .ctrl     (ctrl),
    .req      (req),
    .hit      (hit),
    .dirty    (dirty),
    .mem_addr (mem_addr)
  );

  cache_fsm fsm_i (
    .clk       (clk),
    .rst       (rst),
    .cpu_rden  (cpu.rden),
    .cpu_wren  (cpu.wren),
    .req_rden  (req.rden),
    .req_wren  (req.wren),
    .hit       (hit),
    .dirty     (dirty),
    .mem_ready (mem_ready),
    .ctrl      (ctrl),
    .mem_rden  (mem_rden),
    .mem_wren  (mem_wren),
    .stall     (stall),
    .rvalid    (rvalid)
  );

  cache_data_store data_store_i (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .req         (req),
    .mem_rdata   (mem_rdata),
    .rdata       (rdata),
    .victim_line (victim_line)
  );

  assign mem.rden  = mem_rden;
  assign mem.wren  = mem_wren;
  assign mem.addr  = mem_addr;
  assign mem.wdata = victim_line;

endmodule

// File: dv/tb_dcache.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_dcache;

  localparam int CLK_NS   = 20;
  localparam int NUM_REQS = 2000;
  localparam int LIMIT_NS = (NUM_REQS + 20) * 400 * CLK_NS; // 400 cycles per request

  logic                     clk;
  logic                     rst;
  cache_pkg::cpu_req_t      cpu;
  logic                     stall;
  logic [`CACHE_DATA_W-1:0] rdata;
  logic                     rvalid;
  cache_pkg::mem_req_t      mem;
  logic                     mem_ready;
  cache_pkg::line_t         mem_rdata;

  integer                   seed = 32'h86fffd3e;
  logic [`CACHE_DATA_W-1:0] ref_mem [1024];   // word key {tag[1:0], index, word}
  cache_pkg::line_t         mem_lines [256];  // line key {tag[1:0], index}
  logic [`CACHE_LINES-1:0][`CACHE_TAG_W-1:0] model_tag;
  logic [`CACHE_LINES-1:0]  model_valid;
  logic [`CACHE_LINES-1:0]  model_dirty;
  cache_pkg::cache_addr_u   wb_addr;
  cache_pkg::cache_addr_u   fill_addr;
  cache_pkg::line_t         wb_line;
  logic [`CACHE_DATA_W-1:0] exp_rdata;
  logic                     wb_pending;
  logic                     fill_pending;
  logic                     read_pending;
  logic                     just_issued;
  logic                     last_hit;
  logic                     mem_busy;
  int                       mem_wait;
  int                       issued;

  dcache_top dcache_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(LIMIT_NS);
    stop_with_error("Timeout: the run did not finish within its cycle budget");
  end

  function automatic logic [`CACHE_DATA_W-1:0] fill_word(
    input logic [`CACHE_ADDR_W-1:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5ac3_0f1e; // every address bit matters
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_rdata(input string name, input logic [`CACHE_DATA_W-1:0] got,
                             input logic [`CACHE_DATA_W-1:0] exp);
    if (got !== exp)
      stop_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_mem_line(input string name, input cache_pkg::line_t got,
                                input cache_pkg::line_t exp);
    if (got !== exp)
      stop_with_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_mem_addr(input string name, input cache_pkg::cache_addr_u got,
                                input cache_pkg::cache_addr_u exp);
    if (got !== exp)
      stop_with_error($sformatf("Fail %s: got %h expected %h", name, got.word, exp.word));
  endtask

  // reference model of a direct-mapped, write-back, write-allocate cache
  task automatic issue_request(input cache_pkg::cpu_req_t r);
    logic [`CACHE_INDEX_W-1:0] idx;
    logic [9:0]                wkey;
    logic                      hit;
    idx  = r.addr.f.index;
    wkey = {r.addr.f.tag[1:0], idx, r.addr.f.word_sel};
    hit  = model_valid[idx] && (model_tag[idx] == r.addr.f.tag);
    if (!hit) begin
      if (model_valid[idx] && model_dirty[idx]) begin
        wb_pending      = 1'b1;
        wb_addr         = '0;
        wb_addr.f.tag   = model_tag[idx];
        wb_addr.f.index = idx;
        for (int w = 0; w < `CACHE_WORDS; w++) begin
          wb_line[2'(w)] = ref_mem[{model_tag[idx][1:0], idx, 2'(w)}];
        end
      end
      fill_pending      = 1'b1;
      fill_addr         = '0;
      fill_addr.f.tag   = r.addr.f.tag;
      fill_addr.f.index = idx;
      model_valid[idx]  = 1'b1;
      model_tag[idx]    = r.addr.f.tag;
      model_dirty[idx]  = 1'b0;
    end
    if (r.wren) begin
      ref_mem[wkey]    = r.wdata; // updated at issue
      model_dirty[idx] = 1'b1;
    end
    if (r.rden) begin
      read_pending = 1'b1;
      exp_rdata    = ref_mem[wkey];
    end
    last_hit    = hit;
    just_issued = 1'b1;
    issued++;
  endtask

  task automatic serve_memory();
    logic [7:0] lkey;
    lkey = {mem.addr.f.tag[1:0], mem.addr.f.index};
    if (mem_ready) begin
      mem_ready = 1'b0; // one-cycle pulse
    end else if (mem.rden || mem.wren) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = 1 + {$random(seed)} % 4; // 1 to 4 cycles
      end
      if (mem_wait != 0) begin
        mem_wait--;
      end else begin
        if (mem.wren) begin
          if (!wb_pending) stop_with_error("memory write without a dirty eviction");
          check_mem_addr("mem.addr", mem.addr, wb_addr);
          check_mem_line("mem.wdata", mem.wdata, wb_line);
          mem_lines[lkey] = mem.wdata;
          wb_pending      = 1'b0;
        end else begin
          if (wb_pending) stop_with_error("fill read issued before the write-back");
          if (!fill_pending) stop_with_error("memory read without a miss");
          check_mem_addr("mem.addr", mem.addr, fill_addr);
          mem_rdata    = mem_lines[lkey];
          fill_pending = 1'b0;
        end
        mem_busy  = 1'b0;
        mem_ready = 1'b1;
      end
    end
  endtask

  // checks results, answers memory and drives the next request
  task automatic service_cycle();
    cache_pkg::cpu_req_t r;
    logic [31:0]         rnd;
    if (just_issued) begin
      check_level("stall", stall, !last_hit); // compare cycle
      if (read_pending && last_hit) check_level("rvalid", rvalid, 1'b1);
    end
    just_issued = 1'b0;
    if (rvalid) begin
      if (!read_pending) stop_with_error("rvalid without an outstanding read");
      check_rdata("rdata", rdata, exp_rdata);
      read_pending = 1'b0;
    end
    serve_memory();
    if (!stall) begin
      if (read_pending || wb_pending || fill_pending)
        stop_with_error("stall dropped before the request was complete");
      r   = '0;
      rnd = $random(seed);
      if (issued < NUM_REQS && rnd[12:10] != 3'd0) begin
        r.rden              = rnd[0];
        r.wren              = !rnd[0];
        r.addr.f.tag[1:0]   = (rnd[3:2] == 2'd3) ? 2'd0 : rnd[3:2]; // three tags
        r.addr.f.index      = {2'b00, rnd[7:4]};
        r.addr.f.word_sel   = rnd[9:8];
        r.wdata             = $random(seed);
        issue_request(r);
      end
      cpu = r;
    end
  endtask

  initial begin
    rst          = 1'b1;
    cpu          = '0;
    mem_ready    = 1'b0;
    mem_rdata    = '0;
    model_tag    = '0;
    model_valid  = '0;
    model_dirty  = '0;
    wb_pending   = 1'b0;
    fill_pending = 1'b0;
    read_pending = 1'b0;
    just_issued  = 1'b0;
    last_hit     = 1'b0;
    mem_busy     = 1'b0;
    mem_wait     = 0;
    issued       = 0;
    for (int k = 0; k < 1024; k++) begin
      ref_mem[10'(k)]               = fill_word(k << 2); // key is the word address
      mem_lines[8'(k >> 2)][2'(k)]  = fill_word(k << 2);
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    repeat (6) begin
      @(negedge clk);
      check_level("stall", stall, 1'b0);
      check_level("rvalid", rvalid, 1'b0);
      check_level("mem.rden", mem.rden, 1'b0);
      check_level("mem.wren", mem.wren, 1'b0);
    end
    while (issued < NUM_REQS || just_issued || stall || read_pending) begin
      @(negedge clk);
      service_cycle();
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/cache_pkg.sv
common/ctrl_pkg.sv
cache/cache_tag_store.sv
cache/cache_fsm.sv
cache/cache_data_store.sv
hw/dcache_top.sv
dv/tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module tb_dcache -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi
./obj_dir/Vtb_dcache
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi
exit 0
